/* design/mrdma_pkg.sv */
/*
 * shared widths and enums for the read-DMA ingress stage
 * imported by every RTL block that needs a width or an encoding
 */
package mrdma_pkg;

  // ==================================================
  // address widths
  // ==================================================
  // byte offset inside one 32-byte block
  localparam int addr_align_w = 5;
  // full byte address on the dma port
  localparam int dma_addr_w   = 64;
  // block address, the byte address without its offset bits
  localparam int blk_addr_w   = dma_addr_w - addr_align_w;
  // base address split across two config words
  localparam int base_hi_w    = 32;
  localparam int base_lo_w    = blk_addr_w - base_hi_w;
  // line and surface strides, in blocks
  localparam int stride_w     = 27;

  // ==================================================
  // cube and request widths
  // ==================================================
  // width, height, channel
  localparam int cube_dim_w   = 13;
  // channel block count
  localparam int surf_cnt_w   = 9;
  // request size field
  localparam int dma_size_w   = 15;
  // dma payload is size over address
  localparam int dma_pd_w     = dma_addr_w + dma_size_w;
  // cq payload is cube end over 13 size bits
  localparam int cq_pd_w      = 14;

  // ==================================================
  // encodings
  // ==================================================
  // input precision, int8 packs 32 channels per block
  typedef enum logic [1:0] {
    prec_int8  = 2'd0,
    prec_int16 = 2'd1,
    prec_fp16  = 2'd2
  } precision_e;

  // control state
  typedef enum logic {
    ig_idle = 1'b0,
    ig_busy = 1'b1
  } ig_state_e;

endpackage

/* design/mrdma_ig_ctrl.sv */
/*
 * ingress control: busy flag, cross-gated valids and the accept strobe
 * one request in flight, walk ends on the accept that carries cube end
 */
`timescale 1ns/1ps

module mrdma_ig_ctrl import mrdma_pkg::*; (
  input  logic autosa_core_clk,
  input  logic autosa_core_rstn,
  input  logic op_load,
  input  logic cube_end,
  input  logic dma_rd_req_rdy,
  input  logic ig2cq_prdy,
  output logic busy,
  output logic cmd_accept,
  output logic dma_rd_req_vld,
  output logic ig2cq_pvld
);

  ig_state_e state;
  logic      cmd_done;

  // ==================================================
  // handshake
  // ==================================================
  // dma valid waits on cq ready, cq valid waits on dma ready
  // so both sides accept on the same cycle
  assign dma_rd_req_vld = busy & ig2cq_prdy;
  assign ig2cq_pvld     = busy & dma_rd_req_rdy;

  // accept seen on the dma side, cq accepts with it
  assign cmd_accept = dma_rd_req_vld & dma_rd_req_rdy;

  // last request of the cube taken
  assign cmd_done = cmd_accept & cube_end;

  // ==================================================
  // state
  // ==================================================
  assign busy = (state == ig_busy);

  // a new load has priority over done
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      state <= ig_idle;
    end else if (op_load) begin
      state <= ig_busy;
    end else if (cmd_done) begin
      state <= ig_idle;
    end
  end

endmodule

/* design/mrdma_cube_walker.sv */
/*
 * cube walk: surfaces of channel blocks, lines inside each surface
 * gives the surface and cube end flags for the current request
 */
`timescale 1ns/1ps

module mrdma_cube_walker import mrdma_pkg::*; (
  input  logic                  autosa_core_clk,
  input  logic                  autosa_core_rstn,
  input  logic                  op_load,
  input  logic                  cmd_accept,
  input  logic [cube_dim_w-1:0] cfg_width,
  input  logic [cube_dim_w-1:0] cfg_height,
  input  logic [cube_dim_w-1:0] cfg_channel,
  input  precision_e            cfg_in_precision,
  output logic                  pack_mode,
  output logic [surf_cnt_w-1:0] surf_blocks,
  output logic                  surf_end,
  output logic                  cube_end
);

  logic [surf_cnt_w-1:0] count_c;
  logic [cube_dim_w-1:0] count_h;
  logic                  last_c;
  logic                  last_h;

  // ==================================================
  // config decode
  // ==================================================
  // 1x1 pack, one request for the whole cube
  assign pack_mode = (cfg_width == '0) && (cfg_height == '0);

  // index of the last channel block
  // int8 is 32 channels per block, the rest 16
  always_comb begin
    if (cfg_in_precision == prec_int8) begin
      surf_blocks = {1'b0, cfg_channel[cube_dim_w-1:5]};
    end else begin
      surf_blocks = cfg_channel[cube_dim_w-1:4];
    end
  end

  // ==================================================
  // end flags
  // ==================================================
  assign last_h   = (count_h == cfg_height);
  assign last_c   = (count_c == surf_blocks);
  assign surf_end = pack_mode | last_h;
  assign cube_end = surf_end & (pack_mode | last_c);

  // ==================================================
  // counters
  // ==================================================
  // surface (channel block) count
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      count_c <= '0;
    end else if (op_load) begin
      count_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // line count inside a surface
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      count_h <= '0;
    end else if (op_load) begin
      count_h <= '0;
    end else if (cmd_accept) begin
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

endmodule

/* design/mrdma_addr_gen.sv */
/*
 * block address of the current line request
 * line base steps by line stride, surface base by surface stride
 */
`timescale 1ns/1ps

module mrdma_addr_gen import mrdma_pkg::*; (
  input  logic                  autosa_core_clk,
  input  logic                  autosa_core_rstn,
  input  logic                  op_load,
  input  logic                  cmd_accept,
  input  logic                  surf_end,
  input  logic [base_hi_w-1:0]  cfg_base_hi,
  input  logic [base_lo_w-1:0]  cfg_base_lo,
  input  logic [stride_w-1:0]   cfg_line_stride,
  input  logic [stride_w-1:0]   cfg_surf_stride,
  output logic [blk_addr_w-1:0] blk_addr
);

  logic [blk_addr_w-1:0] cfg_base;
  logic [blk_addr_w-1:0] line_step;
  logic [blk_addr_w-1:0] surf_step;
  logic [blk_addr_w-1:0] base_line;
  logic [blk_addr_w-1:0] base_surf;
  logic [blk_addr_w-1:0] next_surf;

  // ==================================================
  // config
  // ==================================================
  assign cfg_base = {cfg_base_hi, cfg_base_lo};

  // strides widened to the block address
  assign line_step = {{(blk_addr_w-stride_w){1'b0}}, cfg_line_stride};
  assign surf_step = {{(blk_addr_w-stride_w){1'b0}}, cfg_surf_stride};

  // start of the next surface
  assign next_surf = base_surf + surf_step;

  // ==================================================
  // base registers
  // ==================================================
  // surface base only moves at a surface end
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      base_surf <= '0;
    end else if (op_load) begin
      base_surf <= cfg_base;
    end else if (cmd_accept && surf_end) begin
      base_surf <= next_surf;
    end
  end

  // line base restarts from the new surface
  // otherwise next line
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      base_line <= '0;
    end else if (op_load) begin
      base_line <= cfg_base;
    end else if (cmd_accept) begin
      if (surf_end) begin
        base_line <= next_surf;
      end else begin
        base_line <= base_line + line_step;
      end
    end
  end

  // request goes out at the current line
  assign blk_addr = base_line;

endmodule

/* design/mrdma_req_pack.sv */
/*
 * request size select and payload packing for the dma and cq ports
 * purely combinational from the walker and address state
 */
`timescale 1ns/1ps

module mrdma_req_pack import mrdma_pkg::*; (
  input  logic                  pack_mode,
  input  logic [surf_cnt_w-1:0] surf_blocks,
  input  logic [cube_dim_w-1:0] cfg_width,
  input  logic                  cube_end,
  input  logic [blk_addr_w-1:0] blk_addr,
  output logic [dma_pd_w-1:0]   dma_rd_req_pd,
  output logic [cq_pd_w-1:0]    ig2cq_pd
);

  logic [dma_size_w-1:0] req_size;
  logic [dma_addr_w-1:0] req_addr;

  // ==================================================
  // size
  // ==================================================
  // pack mode sends the block count, else the line width
  always_comb begin
    if (pack_mode) begin
      req_size = {{(dma_size_w-surf_cnt_w){1'b0}}, surf_blocks};
    end else begin
      req_size = {{(dma_size_w-cube_dim_w){1'b0}}, cfg_width};
    end
  end

  // ==================================================
  // payloads
  // ==================================================
  // byte address, 32-byte aligned
  assign req_addr = {blk_addr, {addr_align_w{1'b0}}};

  // size sits above the address
  assign dma_rd_req_pd = {req_size, req_addr};

  // cq keeps 13 size bits, cube end on top
  assign ig2cq_pd = {cube_end, req_size[cq_pd_w-2:0]};

endmodule

/* design/mrdma_stall_counter.sv */
/*
 * perf counter of cycles with a dma request held off by the port
 * enable sampled at op_load, count cleared at every op_load
 */
`timescale 1ns/1ps

module mrdma_stall_counter #(
  parameter int stall_cnt_w = 32
) (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  input  logic                   op_load,
  input  logic                   perf_en,
  input  logic                   dma_rd_req_vld,
  input  logic                   dma_rd_req_rdy,
  output logic [stall_cnt_w-1:0] stall_cnt
);

  logic cnt_en;
  logic stall;

  // request offered but not taken
  assign stall = dma_rd_req_vld & ~dma_rd_req_rdy;

  // enable held for the whole operation
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= perf_en;
    end
  end

  // ==================================================
  // count
  // ==================================================
  // clear wins, wraps at full width
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      stall_cnt <= '0;
    end else if (op_load) begin
      stall_cnt <= '0;
    end else if (cnt_en && stall) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

endmodule

/* design/mrdma_ig.sv */
/*
 * read-DMA ingress stage top: walks the feature cube, one dma read
 * and one matching cq command per line, plus a dma stall counter
 */
`timescale 1ns/1ps

module mrdma_ig import mrdma_pkg::*; #(
  parameter int stall_cnt_w = 32
) (
  input  logic                   autosa_core_clk,
  input  logic                   autosa_core_rstn,
  input  logic                   op_load,
  // cube shape
  input  logic [cube_dim_w-1:0]  cfg_width,
  input  logic [cube_dim_w-1:0]  cfg_height,
  input  logic [cube_dim_w-1:0]  cfg_channel,
  input  precision_e             cfg_in_precision,
  // source addressing
  input  logic [base_hi_w-1:0]   cfg_base_hi,
  input  logic [base_lo_w-1:0]   cfg_base_lo,
  input  logic [stride_w-1:0]    cfg_line_stride,
  input  logic [stride_w-1:0]    cfg_surf_stride,
  input  logic                   cfg_ram_type,
  input  logic                   cfg_perf_en,
  // dma read request
  output logic                   dma_rd_req_vld,
  input  logic                   dma_rd_req_rdy,
  output logic [dma_pd_w-1:0]    dma_rd_req_pd,
  output logic                   dma_rd_req_ram_type,
  // completion queue command
  output logic                   ig2cq_pvld,
  input  logic                   ig2cq_prdy,
  output logic [cq_pd_w-1:0]     ig2cq_pd,
  // perf
  output logic [stall_cnt_w-1:0] stall_cnt
);

  // operation in progress
  logic                  busy;
  logic                  cmd_accept;
  logic                  pack_mode;
  logic                  surf_end;
  logic                  cube_end;
  logic [surf_cnt_w-1:0] surf_blocks;
  logic [blk_addr_w-1:0] blk_addr;

  // ==================================================
  // control
  // ==================================================
  mrdma_ig_ctrl i_ctrl (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_load          (op_load),
    .cube_end         (cube_end),
    .dma_rd_req_rdy   (dma_rd_req_rdy),
    .ig2cq_prdy       (ig2cq_prdy),
    .busy             (busy),
    .cmd_accept       (cmd_accept),
    .dma_rd_req_vld   (dma_rd_req_vld),
    .ig2cq_pvld       (ig2cq_pvld)
  );

  // ==================================================
  // datapath
  // ==================================================
  mrdma_cube_walker i_walker (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_load          (op_load),
    .cmd_accept       (cmd_accept),
    .cfg_width        (cfg_width),
    .cfg_height       (cfg_height),
    .cfg_channel      (cfg_channel),
    .cfg_in_precision (cfg_in_precision),
    .pack_mode        (pack_mode),
    .surf_blocks      (surf_blocks),
    .surf_end         (surf_end),
    .cube_end         (cube_end)
  );

  mrdma_addr_gen i_addr_gen (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_load          (op_load),
    .cmd_accept       (cmd_accept),
    .surf_end         (surf_end),
    .cfg_base_hi      (cfg_base_hi),
    .cfg_base_lo      (cfg_base_lo),
    .cfg_line_stride  (cfg_line_stride),
    .cfg_surf_stride  (cfg_surf_stride),
    .blk_addr         (blk_addr)
  );

  mrdma_req_pack i_req_pack (
    .pack_mode        (pack_mode),
    .surf_blocks      (surf_blocks),
    .cfg_width        (cfg_width),
    .cube_end         (cube_end),
    .blk_addr         (blk_addr),
    .dma_rd_req_pd    (dma_rd_req_pd),
    .ig2cq_pd         (ig2cq_pd)
  );

  mrdma_stall_counter #(
    .stall_cnt_w      (stall_cnt_w)
  ) i_stall_counter (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_load          (op_load),
    .perf_en          (cfg_perf_en),
    .dma_rd_req_vld   (dma_rd_req_vld),
    .dma_rd_req_rdy   (dma_rd_req_rdy),
    .stall_cnt        (stall_cnt)
  );

  // ram type goes out with every request
  assign dma_rd_req_ram_type = cfg_ram_type;

endmodule

/* include/mrdma_ig_cases.svh */
/*
 * operation table for the ingress testbench, one row per load
 * included inside the testbench module after the package import
 */
`ifndef MRDMA_IG_CASES_SVH
`define MRDMA_IG_CASES_SVH

// columns: width, height, channel, precision, block base, line stride,
// surface stride, ram type, perf enable, ready percent, request count
typedef struct packed {
  logic [cube_dim_w-1:0] width;
  logic [cube_dim_w-1:0] height;
  logic [cube_dim_w-1:0] channel;
  precision_e            prec;
  logic [blk_addr_w-1:0] base;
  logic [stride_w-1:0]   line_stride;
  logic [stride_w-1:0]   surf_stride;
  logic                  ram_type;
  logic                  perf_en;
  logic [7:0]            ready_pct;
  logic [15:0]           exp_reqs;
} case_row_t;

localparam int num_cases = 8;

function automatic void get_case(input int idx, output string name, output case_row_t row);
  row = '0;
  name = "none";
  case (idx)
    // 1x1 pack, 100 channels int8 is 3 blocks
    0: begin
      name = "pack_int8";
      row = '{0, 0, 100, prec_int8, 59'h100, 0, 0, 0, 1, 60, 1};
    end
    1: begin
      name = "int8_surfaces";
      row = '{15, 3, 64, prec_int8, 59'h2000, 4, 64, 1, 1, 50, 12};
    end
    2: begin
      name = "int16_lines";
      row = '{31, 5, 40, prec_int16, 59'h10, 8, 100, 0, 0, 70, 18};
    end
    3: begin
      name = "fp16_surfaces";
      row = '{7, 1, 80, prec_fp16, 59'h7ff_0000, 3, 16, 1, 1, 40, 12};
    end
    // not pack mode, width is nonzero
    4: begin
      name = "single_line";
      row = '{100, 0, 10, prec_int16, 59'h5, 1, 1, 0, 1, 50, 1};
    end
    5: begin
      name = "full_ready";
      row = '{63, 7, 31, prec_int8, 59'h400, 2, 32, 1, 1, 100, 8};
    end
    6: begin
      name = "pack_fp16";
      row = '{0, 0, 200, prec_fp16, 59'h3_0000_0040, 0, 0, 0, 1, 30, 1};
    end
    // block address wraps at the top
    7: begin
      name = "high_base";
      row = '{12, 2, 32, prec_int8, 59'h7ff_ffff_ffff_fff0, 27'h10, 27'h7ff_ffff, 1, 0, 50, 6};
    end
    default: begin
      name = "none";
    end
  endcase
endfunction

`endif

/* tb/mrdma_ig_tb.sv */
/*
 * testbench for the read-DMA ingress stage: runs every table row under
 * random ready and checks each request against a model of the cube walk
 */
`timescale 1ns/1ps

module mrdma_ig_tb import mrdma_pkg::*; ();

  `include "mrdma_ig_cases.svh"

  localparam int stall_cnt_w = 32;
  localparam int wait_limit  = 4000;
  localparam int idle_cycles = 20;

  logic                   autosa_core_clk;
  logic                   autosa_core_rstn;
  logic                   op_load;
  logic [cube_dim_w-1:0]  cfg_width;
  logic [cube_dim_w-1:0]  cfg_height;
  logic [cube_dim_w-1:0]  cfg_channel;
  precision_e             cfg_in_precision;
  logic [base_hi_w-1:0]   cfg_base_hi;
  logic [base_lo_w-1:0]   cfg_base_lo;
  logic [stride_w-1:0]    cfg_line_stride;
  logic [stride_w-1:0]    cfg_surf_stride;
  logic                   cfg_ram_type;
  logic                   cfg_perf_en;
  logic                   dma_rd_req_vld;
  logic                   dma_rd_req_rdy;
  logic [dma_pd_w-1:0]    dma_rd_req_pd;
  logic                   dma_rd_req_ram_type;
  logic                   ig2cq_pvld;
  logic                   ig2cq_prdy;
  logic [cq_pd_w-1:0]     ig2cq_pd;
  logic [stall_cnt_w-1:0] stall_cnt;

  // test state, shared by the run task and the monitor
  string                 cur_name;
  case_row_t             cur;
  integer                seed = 32'h8a3f;
  int                    errors;
  int                    checks;
  int                    tests_failed;
  int                    case_errs;
  int                    got_reqs;
  int                    seen_stalls;
  int                    exp_c;
  int                    exp_h;
  bit                    active;
  bit                    walk_done;
  bit                    timed_out;
  bit                    prev_hold;
  logic [dma_pd_w-1:0]   prev_pd;

  mrdma_ig #(
    .stall_cnt_w (stall_cnt_w)
  ) i_mrdma_ig (.*);

  always #5 autosa_core_clk = ~autosa_core_clk;

  // ==================================================
  // reporting and compare
  // ==================================================
  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    errors++;
    case_errs++;
    $display("[FAIL] %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
  endtask

  task automatic report_error(input string msg);
    errors++;
    case_errs++;
    $display("error in %s: %s", cur_name, msg);
  endtask

  task automatic check_addr(input string what, input logic [dma_addr_w-1:0] exp,
                            input logic [dma_addr_w-1:0] act);
    checks++;
    if (act !== exp) report_mismatch(what, exp, act);
  endtask

  task automatic check_size(input string what, input logic [dma_size_w-1:0] exp,
                            input logic [dma_size_w-1:0] act);
    checks++;
    if (act !== exp) report_mismatch(what, exp, act);
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) report_mismatch(what, exp, act);
  endtask

  task automatic check_cnt(input string what, input logic [stall_cnt_w-1:0] exp,
                           input logic [stall_cnt_w-1:0] act);
    checks++;
    if (act !== exp) report_mismatch(what, exp, act);
  endtask

  // ==================================================
  // walk model
  // ==================================================
  function automatic bit model_pack();
    return (cur.width == 0) && (cur.height == 0);
  endfunction

  // last block index, int8 is 32 channels per block, others 16
  function automatic int model_blocks();
    if (cur.prec == prec_int8) return cur.channel / 32;
    return cur.channel / 16;
  endfunction

  function automatic logic [dma_size_w-1:0] model_size();
    if (model_pack()) return model_blocks();
    return cur.width;
  endfunction

  // byte address of surface c, line h
  function automatic logic [dma_addr_w-1:0] model_addr(input int c, input int h);
    logic [dma_addr_w-1:0] blk;
    blk = {5'd0, cur.base} + c * cur.surf_stride + h * cur.line_stride;
    return blk << addr_align_w;
  endfunction

  // ==================================================
  // monitor, sampled at the falling edge
  // ==================================================
  always @(negedge autosa_core_clk) begin : monitor
    logic last;
    logic dma_acc;
    dma_acc = dma_rd_req_vld & dma_rd_req_rdy;
    if (autosa_core_rstn && !active) begin
      if (dma_rd_req_vld || ig2cq_pvld) report_error("request valid while idle");
    end else if (autosa_core_rstn) begin
      // both ports take the command on the same cycle
      check_flag("cq accept", dma_acc, ig2cq_pvld & ig2cq_prdy);
      // payload held since the last stalled cycle
      if (prev_hold) begin
        check_addr("held addr", prev_pd[dma_addr_w-1:0], dma_rd_req_pd[dma_addr_w-1:0]);
        check_size("held size", prev_pd[dma_pd_w-1:dma_addr_w],
                   dma_rd_req_pd[dma_pd_w-1:dma_addr_w]);
      end
      if (dma_rd_req_vld && !dma_rd_req_rdy) seen_stalls++;
      if (dma_acc) begin
        last = model_pack() || ((exp_c == model_blocks()) && (exp_h == cur.height));
        check_addr("addr", model_addr(exp_c, exp_h), dma_rd_req_pd[dma_addr_w-1:0]);
        check_size("dma size", model_size(), dma_rd_req_pd[dma_pd_w-1:dma_addr_w]);
        check_size("cq size", model_size(), {2'b00, ig2cq_pd[cq_pd_w-2:0]});
        check_flag("cube end", last, ig2cq_pd[cq_pd_w-1]);
        check_flag("ram type", cur.ram_type, dma_rd_req_ram_type);
        got_reqs++;
        // next line, or first line of the next surface
        if (exp_h == cur.height) begin
          exp_h = 0;
          exp_c++;
        end else begin
          exp_h++;
        end
        if (ig2cq_pd[cq_pd_w-1]) begin
          active = 0;
          walk_done = 1;
        end
      end
      prev_hold = dma_rd_req_vld & ~dma_rd_req_rdy;
      prev_pd = dma_rd_req_pd;
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  task automatic drive_ready(input int pct);
    dma_rd_req_rdy = ($unsigned($random(seed)) % 100) < pct;
    ig2cq_prdy     = ($unsigned($random(seed)) % 100) < pct;
  endtask

  // readies high, monitor flags any valid
  task automatic idle_window();
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
    repeat (idle_cycles) @(posedge autosa_core_clk);
    #1;
  endtask

  task automatic run_case(input int idx);
    int wait_cnt;
    int exp_reqs;
    get_case(idx, cur_name, cur);
    case_errs = 0;
    got_reqs = 0;
    seen_stalls = 0;
    exp_c = 0;
    exp_h = 0;
    prev_hold = 0;
    walk_done = 0;
    cfg_width = cur.width;
    cfg_height = cur.height;
    cfg_channel = cur.channel;
    cfg_in_precision = cur.prec;
    cfg_base_hi = cur.base[blk_addr_w-1:base_lo_w];
    cfg_base_lo = cur.base[base_lo_w-1:0];
    cfg_line_stride = cur.line_stride;
    cfg_surf_stride = cur.surf_stride;
    cfg_ram_type = cur.ram_type;
    cfg_perf_en = cur.perf_en;
    op_load = 1'b1;
    active = 1;
    drive_ready(cur.ready_pct);
    @(posedge autosa_core_clk);
    #1;
    op_load = 1'b0;
    // wait for the cube end accept
    wait_cnt = 0;
    while (!walk_done && wait_cnt < wait_limit) begin
      drive_ready(cur.ready_pct);
      @(posedge autosa_core_clk);
      #1;
      wait_cnt++;
    end
    if (!walk_done) begin
      report_error("timed out waiting for the cube end request");
      timed_out = 1;
      active = 0;
    end else begin
      idle_window();
      exp_reqs = model_pack() ? 1 : (cur.height + 1) * (model_blocks() + 1);
      if (got_reqs != exp_reqs || got_reqs != cur.exp_reqs) begin
        report_error($sformatf("saw %0d requests, wanted %0d", got_reqs, exp_reqs));
      end
      check_cnt("stall count", cur.perf_en ? seen_stalls : 0, stall_cnt);
    end
    if (case_errs != 0) tests_failed++;
    $display("test %s: %0d requests, %0d stall cycles, %0d errors",
             cur_name, got_reqs, seen_stalls, case_errs);
  endtask

  initial begin
    autosa_core_clk = 1'b0;
    autosa_core_rstn = 1'b0;
    op_load = 1'b0;
    cfg_width = '0;
    cfg_height = '0;
    cfg_channel = '0;
    cfg_in_precision = prec_int8;
    cfg_base_hi = '0;
    cfg_base_lo = '0;
    cfg_line_stride = '0;
    cfg_surf_stride = '0;
    cfg_ram_type = 1'b0;
    cfg_perf_en = 1'b0;
    dma_rd_req_rdy = 1'b0;
    ig2cq_prdy = 1'b0;
    cur = '0;
    cur_name = "reset_idle";
    errors = 0;
    checks = 0;
    tests_failed = 0;
    timed_out = 0;
    active = 0;
    repeat (3) @(posedge autosa_core_clk);
    #1;
    autosa_core_rstn = 1'b1;
    // no request out of reset
    idle_window();
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
      if (timed_out) break;
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             num_cases, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
design/mrdma_pkg.sv
design/mrdma_ig_ctrl.sv
design/mrdma_cube_walker.sv
design/mrdma_addr_gen.sv
design/mrdma_req_pack.sv
design/mrdma_stall_counter.sv
design/mrdma_ig.sv
tb/mrdma_ig_tb.sv
